//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_control_unit
FILELIST  = control_unit.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

//--- control_unit.f
+incdir+hw
hw/control_unit_pkg.sv
hw/instr_decoder.sv
hw/ctrl_sequencer.sv
hw/ctrl_outputs.sv
hw/control_unit.sv
verification/tb_clock_gen.sv
verification/control_unit_assert.sv
verification/tb_control_unit.sv

//--- hw/control_unit.sv
`default_nettype none

module control_unit import control_unit_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  opcode_t    opcode,
    input  funct_t     funct,
    input  logic       overflow,
    input  logic       zero,
    output iord_t      iord,
    output logic       mem_wr,
    output logic       ir_wr,
    output logic       reg_wr,
    output logic       wr_a,
    output logic       wr_b,
    output reg_dst_t   reg_dst,
    output data_src_t  data_src,
    output alu_src_a_t alu_src_a,
    output alu_src_b_t alu_src_b,
    output alu_op_t    alu_op,
    output logic       alu_out_wr,
    output pc_src_t    pc_source,
    output logic       pc_wr,
    output logic       epc_wr,
    output cause_t     cause_control,
    output size_ctl_t  load_control,
    output size_ctl_t  store_control,
    output shift_ctl_t shift_control
);

    instr_class_t instr_class;
    alu_op_t      dec_alu_op;      // Operation wanted by the instruction
    size_ctl_t    size;
    logic         traps_overflow;
    logic         branch_on_zero;
    shift_ctl_t   shift_kind;
    state_t       state;

    instr_decoder i_decoder (
        .opcode         (opcode),
        .funct          (funct),
        .instr_class    (instr_class),
        .alu_op         (dec_alu_op),
        .size           (size),
        .traps_overflow (traps_overflow),
        .branch_on_zero (branch_on_zero),
        .shift_kind     (shift_kind)
    );

    ctrl_sequencer i_sequencer (
        .clk            (clk),
        .reset          (reset),
        .instr_class    (instr_class),
        .traps_overflow (traps_overflow),
        .overflow       (overflow),
        .state          (state)
    );

    ctrl_outputs i_outputs (
        .state          (state),
        .alu_op         (dec_alu_op),
        .size           (size),
        .branch_on_zero (branch_on_zero),
        .shift_kind     (shift_kind),
        .zero           (zero),
        .iord           (iord),
        .mem_wr         (mem_wr),
        .ir_wr          (ir_wr),
        .reg_wr         (reg_wr),
        .wr_a           (wr_a),
        .wr_b           (wr_b),
        .reg_dst        (reg_dst),
        .data_src       (data_src),
        .alu_src_a      (alu_src_a),
        .alu_src_b      (alu_src_b),
        .alu_op_out     (alu_op),
        .alu_out_wr     (alu_out_wr),
        .pc_source      (pc_source),
        .pc_wr          (pc_wr),
        .epc_wr         (epc_wr),
        .cause_control  (cause_control),
        .load_control   (load_control),
        .store_control  (store_control),
        .shift_control  (shift_control)
    );

endmodule

`default_nettype wire

//--- hw/control_unit_pkg.sv
`default_nettype none

`include "control_unit_settings.svh"

package control_unit_pkg;

    // Instruction fields
    typedef logic [`CU_OPCODE_W-1:0]   opcode_t;
    typedef logic [`CU_FUNCT_W-1:0]    funct_t;

    // Datapath control fields
    typedef logic [`CU_ALU_OP_W-1:0]   alu_op_t;
    typedef logic [`CU_PC_SRC_W-1:0]   pc_src_t;
    typedef logic [`CU_IORD_W-1:0]     iord_t;
    typedef logic [`CU_DATA_SRC_W-1:0] data_src_t;
    typedef logic [`CU_REG_DST_W-1:0]  reg_dst_t;
    typedef logic [`CU_SRC_A_W-1:0]    alu_src_a_t;
    typedef logic [`CU_SRC_B_W-1:0]    alu_src_b_t;
    typedef logic [`CU_CAUSE_W-1:0]    cause_t;
    typedef logic [`CU_SIZE_W-1:0]     size_ctl_t;
    typedef logic [`CU_SHIFT_W-1:0]    shift_ctl_t;

    // One decoder class per path through the FSM
    typedef enum logic [3:0] {
        R_ALU, SHIFT, JUMP_REG, I_ALU, LOAD, STORE, BRANCH, JUMP, JUMP_LINK, ILLEGAL
    } instr_class_t;

    typedef enum logic [`CU_STATE_W-1:0] {
        reset_start  = 6'b111111,
        fetch        = 6'b000001,
        decode       = 6'b000010,
        illegal_exc  = 6'b000011,
        overflow_exc = 6'b000100,
        r_exec       = 6'b000110,
        r_wb         = 6'b000111,
        jr           = 6'b001000,
        shift_exec   = 6'b001111,
        i_exec       = 6'b010000,
        i_wb         = 6'b010001,
        branch       = 6'b010010,
        mem_addr     = 6'b010011,
        load_mem     = 6'b010100,
        load_wb      = 6'b010101,
        store_mem    = 6'b010110,
        jump         = 6'b010111,
        jump_link    = 6'b011000
    } state_t;

endpackage

`default_nettype wire

//--- hw/control_unit_settings.svh
`ifndef CONTROL_UNIT_SETTINGS_SVH
`define CONTROL_UNIT_SETTINGS_SVH

// Instruction field and control widths
`define CU_OPCODE_W    6
`define CU_FUNCT_W     6
`define CU_ALU_OP_W    3
`define CU_PC_SRC_W    3
`define CU_IORD_W      3
`define CU_DATA_SRC_W  4
`define CU_REG_DST_W   2
`define CU_SRC_A_W     2
`define CU_SRC_B_W     3
`define CU_CAUSE_W     2
`define CU_SIZE_W      2
`define CU_SHIFT_W     3
`define CU_STATE_W     6

// Opcodes
`define CU_OP_R_TYPE   6'b000000
`define CU_OP_LW       6'b100011
`define CU_OP_LB       6'b100000
`define CU_OP_SW       6'b101011
`define CU_OP_SB       6'b101000
`define CU_OP_ADDI     6'b001000
`define CU_OP_ANDI     6'b001100
`define CU_OP_ORI      6'b001101
`define CU_OP_SLTI     6'b001010
`define CU_OP_BEQ      6'b000100
`define CU_OP_BNE      6'b000101
`define CU_OP_J        6'b000010
`define CU_OP_JAL      6'b000011

// Funct field under R-type
`define CU_F_ADD       6'b100000
`define CU_F_SUB       6'b100010
`define CU_F_AND       6'b100100
`define CU_F_OR        6'b100101
`define CU_F_SLT       6'b101010
`define CU_F_JR        6'b001000
`define CU_F_SLL       6'b000000
`define CU_F_SRA       6'b000011

// ALU operations
`define CU_ALU_ADD     3'd1
`define CU_ALU_SUB     3'd2
`define CU_ALU_AND     3'd3
`define CU_ALU_OR      3'd4
`define CU_ALU_SLT     3'd5

// PC source, memory address and ALU operand selects
`define CU_PC_ALU      3'd0
`define CU_PC_TARGET   3'd1
`define CU_PC_REG_A    3'd2
`define CU_PC_EXC      3'd3   // Exception vector
`define CU_IORD_PC     3'd0
`define CU_IORD_ALU    3'd1
`define CU_SRCA_PC     2'd0
`define CU_SRCA_REG_A  2'd1
`define CU_SRCB_REG_B  3'd0
`define CU_SRCB_FOUR   3'd1
`define CU_SRCB_IMM    3'd2
`define CU_SRCB_IMM_SH 3'd3   // Sign-extended offset shifted by two

// Register write data and destination
`define CU_DATA_ALU    4'd0
`define CU_DATA_MDR    4'd1
`define CU_DATA_PC4    4'd4
`define CU_DATA_SHIFT  4'd5
`define CU_DST_RT      2'd0
`define CU_DST_RD      2'd1
`define CU_DST_R31     2'd3

// Exception cause, access size and shifter operation
`define CU_CAUSE_OVF   2'd0
`define CU_CAUSE_ILL   2'd2
`define CU_SIZE_BYTE   2'd1
`define CU_SIZE_WORD   2'd2
`define CU_SHIFT_SLL   3'd1
`define CU_SHIFT_SRA   3'd2

`endif

//--- hw/ctrl_outputs.sv
`default_nettype none

`include "control_unit_settings.svh"

module ctrl_outputs import control_unit_pkg::*; (
    input  state_t     state,
    input  alu_op_t    alu_op,
    input  size_ctl_t  size,
    input  logic       branch_on_zero,
    input  shift_ctl_t shift_kind,
    input  logic       zero,
    output iord_t      iord,
    output logic       mem_wr,
    output logic       ir_wr,
    output logic       reg_wr,
    output logic       wr_a,
    output logic       wr_b,
    output reg_dst_t   reg_dst,
    output data_src_t  data_src,
    output alu_src_a_t alu_src_a,
    output alu_src_b_t alu_src_b,
    output alu_op_t    alu_op_out,
    output logic       alu_out_wr,
    output pc_src_t    pc_source,
    output logic       pc_wr,
    output logic       epc_wr,
    output cause_t     cause_control,
    output size_ctl_t  load_control,
    output size_ctl_t  store_control,
    output shift_ctl_t shift_control
);

    always_comb begin
        // Neutral values; reset_start keeps all of them
        iord          = `CU_IORD_PC;
        mem_wr        = 1'b0;
        ir_wr         = 1'b0;
        reg_wr        = 1'b0;
        wr_a          = 1'b0;
        wr_b          = 1'b0;
        reg_dst       = `CU_DST_RT;
        data_src      = `CU_DATA_ALU;
        alu_src_a     = `CU_SRCA_PC;
        alu_src_b     = `CU_SRCB_REG_B;
        alu_op_out    = '0;
        alu_out_wr    = 1'b0;
        pc_source     = `CU_PC_ALU;
        pc_wr         = 1'b0;
        epc_wr        = 1'b0;
        cause_control = `CU_CAUSE_OVF;
        load_control  = '0;
        store_control = '0;
        shift_control = '0;

        case (state)
            fetch: begin
                alu_src_b  = `CU_SRCB_FOUR;  // PC + 4
                alu_op_out = `CU_ALU_ADD;
                alu_out_wr = 1'b1;
                ir_wr      = 1'b1;
                pc_wr      = 1'b1;
            end
            decode: begin
                // Read rs and rt, precompute the branch target
                wr_a       = 1'b1;
                wr_b       = 1'b1;
                alu_src_b  = `CU_SRCB_IMM_SH;
                alu_op_out = `CU_ALU_ADD;
                alu_out_wr = 1'b1;
            end
            r_exec: begin
                alu_src_a  = `CU_SRCA_REG_A;
                alu_op_out = alu_op;
                alu_out_wr = 1'b1;
            end
            i_exec: begin
                alu_src_a  = `CU_SRCA_REG_A;
                alu_src_b  = `CU_SRCB_IMM;
                alu_op_out = alu_op;
                alu_out_wr = 1'b1;
            end
            r_wb: begin
                reg_dst = `CU_DST_RD;
                reg_wr  = 1'b1;
            end
            i_wb:   reg_wr = 1'b1;  // ALU result into rt
            shift_exec: begin
                shift_control = shift_kind;
                data_src      = `CU_DATA_SHIFT;
                reg_dst       = `CU_DST_RD;
                reg_wr        = 1'b1;
            end
            jr: begin
                pc_source = `CU_PC_REG_A;
                pc_wr     = 1'b1;
            end
            branch: begin
                alu_src_a  = `CU_SRCA_REG_A;
                alu_op_out = `CU_ALU_SUB;
                alu_out_wr = 1'b1;
                pc_source  = `CU_PC_TARGET;
                pc_wr      = (zero == branch_on_zero);
            end
            mem_addr: begin
                alu_src_a  = `CU_SRCA_REG_A;
                alu_src_b  = `CU_SRCB_IMM;
                alu_op_out = `CU_ALU_ADD;
                alu_out_wr = 1'b1;
            end
            load_mem: begin
                iord         = `CU_IORD_ALU;
                load_control = size;
            end
            load_wb: begin
                data_src = `CU_DATA_MDR;
                reg_wr   = 1'b1;
            end
            store_mem: begin
                iord          = `CU_IORD_ALU;
                mem_wr        = 1'b1;
                store_control = size;
            end
            jump: begin
                pc_source = `CU_PC_TARGET;
                pc_wr     = 1'b1;
            end
            jump_link: begin
                data_src  = `CU_DATA_PC4;  // Return address
                reg_dst   = `CU_DST_R31;
                reg_wr    = 1'b1;
                pc_source = `CU_PC_TARGET;
                pc_wr     = 1'b1;
            end
            illegal_exc, overflow_exc: begin
                epc_wr        = 1'b1;
                cause_control = (state == illegal_exc) ? `CU_CAUSE_ILL : `CU_CAUSE_OVF;
                pc_source     = `CU_PC_EXC;
                pc_wr         = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/ctrl_sequencer.sv
`default_nettype none

module ctrl_sequencer import control_unit_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  instr_class_t instr_class,
    input  logic         traps_overflow,
    input  logic         overflow,
    output state_t       state
);

    state_t next_state;
    logic   take_trap;

    // Overflow only matters for add, sub and addi
    assign take_trap = overflow && traps_overflow;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= reset_start;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = fetch;

        case (state)
            reset_start: next_state = fetch;
            fetch:       next_state = decode;

            decode: begin
                case (instr_class)
                    R_ALU:       next_state = r_exec;
                    SHIFT:       next_state = shift_exec;
                    JUMP_REG:    next_state = jr;
                    I_ALU:       next_state = i_exec;
                    LOAD, STORE: next_state = mem_addr;
                    BRANCH:      next_state = branch;
                    JUMP:        next_state = jump;
                    JUMP_LINK:   next_state = jump_link;
                    default:     next_state = illegal_exc;
                endcase
            end

            r_exec: begin
                if (take_trap) begin
                    next_state = overflow_exc;  // Skip the writeback
                end else begin
                    next_state = r_wb;
                end
            end

            i_exec: begin
                if (take_trap) begin
                    next_state = overflow_exc;
                end else begin
                    next_state = i_wb;
                end
            end

            mem_addr: begin
                if (instr_class == LOAD) begin
                    next_state = load_mem;
                end else begin
                    next_state = store_mem;
                end
            end

            load_mem: next_state = load_wb;

            // Last state of every instruction
            r_wb, i_wb, load_wb, store_mem, shift_exec, jr, branch,
            jump, jump_link, illegal_exc, overflow_exc: next_state = fetch;

            default: next_state = fetch;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/instr_decoder.sv
`default_nettype none

`include "control_unit_settings.svh"

module instr_decoder import control_unit_pkg::*; (
    input  opcode_t      opcode,
    input  funct_t       funct,
    output instr_class_t instr_class,
    output alu_op_t      alu_op,
    output size_ctl_t    size,
    output logic         traps_overflow,
    output logic         branch_on_zero,
    output shift_ctl_t   shift_kind
);

    always_comb begin
        instr_class    = ILLEGAL;  // Anything not matched below
        alu_op         = '0;
        size           = '0;
        traps_overflow = 1'b0;
        shift_kind     = '0;

        case (opcode)
            `CU_OP_R_TYPE: begin
                case (funct)
                    `CU_F_ADD: begin
                        instr_class    = R_ALU;
                        alu_op         = `CU_ALU_ADD;
                        traps_overflow = 1'b1;
                    end
                    `CU_F_SUB: begin
                        instr_class    = R_ALU;
                        alu_op         = `CU_ALU_SUB;
                        traps_overflow = 1'b1;
                    end
                    `CU_F_AND: begin
                        instr_class = R_ALU;
                        alu_op      = `CU_ALU_AND;
                    end
                    `CU_F_OR: begin
                        instr_class = R_ALU;
                        alu_op      = `CU_ALU_OR;
                    end
                    `CU_F_SLT: begin
                        instr_class = R_ALU;
                        alu_op      = `CU_ALU_SLT;
                    end
                    `CU_F_SLL: begin
                        instr_class = SHIFT;
                        shift_kind  = `CU_SHIFT_SLL;
                    end
                    `CU_F_SRA: begin
                        instr_class = SHIFT;
                        shift_kind  = `CU_SHIFT_SRA;
                    end
                    `CU_F_JR:  instr_class = JUMP_REG;
                    default:   instr_class = ILLEGAL;
                endcase
            end
            `CU_OP_ADDI: begin
                instr_class    = I_ALU;
                alu_op         = `CU_ALU_ADD;
                traps_overflow = 1'b1;  // Only signed immediate add traps
            end
            `CU_OP_ANDI: begin
                instr_class = I_ALU;
                alu_op      = `CU_ALU_AND;
            end
            `CU_OP_ORI: begin
                instr_class = I_ALU;
                alu_op      = `CU_ALU_OR;
            end
            `CU_OP_SLTI: begin
                instr_class = I_ALU;
                alu_op      = `CU_ALU_SLT;
            end
            // Address is base plus offset for every memory access
            `CU_OP_LW, `CU_OP_LB: begin
                instr_class = LOAD;
                alu_op      = `CU_ALU_ADD;
                size        = (opcode == `CU_OP_LW) ? `CU_SIZE_WORD : `CU_SIZE_BYTE;
            end
            `CU_OP_SW, `CU_OP_SB: begin
                instr_class = STORE;
                alu_op      = `CU_ALU_ADD;
                size        = (opcode == `CU_OP_SW) ? `CU_SIZE_WORD : `CU_SIZE_BYTE;
            end
            `CU_OP_BEQ, `CU_OP_BNE: instr_class = BRANCH;
            `CU_OP_J:               instr_class = JUMP;
            `CU_OP_JAL:             instr_class = JUMP_LINK;
            default:                instr_class = ILLEGAL;
        endcase
    end

    // beq takes the branch on zero, bne on nonzero
    assign branch_on_zero = (opcode == `CU_OP_BEQ);

endmodule

`default_nettype wire

//--- verification/control_unit_assert.sv
`default_nettype none

`include "control_unit_settings.svh"

module control_unit_assert import control_unit_pkg::*; (
    input logic       clk,
    input logic       reset,
    input iord_t      iord,
    input logic       mem_wr,
    input logic       ir_wr,
    input logic       reg_wr,
    input logic       wr_a,
    input logic       wr_b,
    input reg_dst_t   reg_dst,
    input data_src_t  data_src,
    input alu_src_a_t alu_src_a,
    input alu_src_b_t alu_src_b,
    input alu_op_t    alu_op,
    input logic       alu_out_wr,
    input pc_src_t    pc_source,
    input logic       pc_wr,
    input logic       epc_wr,
    input cause_t     cause_control,
    input size_ctl_t  load_control,
    input size_ctl_t  store_control,
    input shift_ctl_t shift_control
);

    // A state writes memory or the register file, never both
    assert property (@(posedge clk) disable iff (reset) !(mem_wr && reg_wr))
        else $error("mem_wr and reg_wr are high together");

    assert property (@(posedge clk) disable iff (reset) ir_wr |-> pc_wr)
        else $error("ir_wr without pc_wr");

    assert property (@(posedge clk) disable iff (reset) epc_wr |-> (pc_source == `CU_PC_EXC))
        else $error("epc_wr without the exception vector as PC source");

    assert property (@(posedge clk) reset |-> ({iord, mem_wr, ir_wr, reg_wr, wr_a, wr_b,
        reg_dst, data_src, alu_src_a, alu_src_b, alu_op, alu_out_wr, pc_source, pc_wr,
        epc_wr, cause_control, load_control, store_control, shift_control} == '0))
        else $error("control output active during reset");

endmodule

bind control_unit control_unit_assert i_assert (.*);

`default_nettype wire

//--- verification/control_unit_stimulus.txt
// op fn ovf zero | cycles alu reg_wr dst dsrc mem_wr load store epc cause pc_wr shift
// zero is used only by beq and bne; ff in the op column ends the list
00 20 0 0 4 1 1 1 0 0 0 0 0 0 0 0  // add
00 22 0 0 4 2 1 1 0 0 0 0 0 0 0 0  // sub
00 24 0 0 4 3 1 1 0 0 0 0 0 0 0 0  // and
00 25 0 0 4 4 1 1 0 0 0 0 0 0 0 0  // or
00 2a 0 0 4 5 1 1 0 0 0 0 0 0 0 0  // slt
00 00 0 0 3 0 1 1 5 0 0 0 0 0 0 1  // sll
00 03 0 0 3 0 1 1 5 0 0 0 0 0 0 2  // sra
00 08 0 0 3 0 0 0 0 0 0 0 0 0 1 0  // jr
08 00 0 0 4 1 1 0 0 0 0 0 0 0 0 0  // addi
0c 00 0 0 4 3 1 0 0 0 0 0 0 0 0 0  // andi
0d 00 0 0 4 4 1 0 0 0 0 0 0 0 0 0  // ori
0a 00 0 0 4 5 1 0 0 0 0 0 0 0 0 0  // slti
00 20 1 0 4 1 0 0 0 0 0 0 1 0 1 0  // add with overflow
00 22 1 0 4 2 0 0 0 0 0 0 1 0 1 0  // sub with overflow
08 00 1 0 4 1 0 0 0 0 0 0 1 0 1 0  // addi with overflow
00 24 1 0 4 3 1 1 0 0 0 0 0 0 0 0  // and ignores overflow
0d 00 1 0 4 4 1 0 0 0 0 0 0 0 0 0  // ori ignores overflow
00 2a 1 0 4 5 1 1 0 0 0 0 0 0 0 0  // slt ignores overflow
23 00 0 0 5 1 1 0 1 0 2 0 0 0 0 0  // lw
20 00 0 0 5 1 1 0 1 0 1 0 0 0 0 0  // lb
2b 00 0 0 4 1 0 0 0 1 0 2 0 0 0 0  // sw
28 00 0 0 4 1 0 0 0 1 0 1 0 0 0 0  // sb
04 00 0 1 3 2 0 0 0 0 0 0 0 0 1 0  // beq taken
04 00 0 0 3 2 0 0 0 0 0 0 0 0 0 0  // beq not taken
05 00 0 0 3 2 0 0 0 0 0 0 0 0 1 0  // bne taken
05 00 0 1 3 2 0 0 0 0 0 0 0 0 0 0  // bne not taken
02 00 0 0 3 0 0 0 0 0 0 0 0 0 1 0  // j
03 00 0 0 3 0 1 3 4 0 0 0 0 0 1 0  // jal
3f 00 0 0 3 0 0 0 0 0 0 0 1 2 1 0  // undefined opcode
00 3f 0 0 3 0 0 0 0 0 0 0 1 2 1 0  // undefined funct
01 00 0 0 3 0 0 0 0 0 0 0 1 2 1 0  // undefined opcode
ff

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 4;   // Period of 8
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;  // Released just after an edge
    end

endmodule

`default_nettype wire

//--- verification/tb_control_unit.sv
`default_nettype none

`include "control_unit_settings.svh"

module tb_control_unit import control_unit_pkg::*; ();

    localparam int         FIELDS    = 16;     // Columns per stimulus line
    localparam int         MAX_LINES = 32;
    localparam logic [7:0] END_MARK  = 8'hff;  // Opcode column of the last line

    // Column positions in the stimulus file
    localparam int C_OPCODE = 0;
    localparam int C_FUNCT  = 1;
    localparam int C_OVF    = 2;
    localparam int C_ZERO   = 3;
    localparam int C_CYCLES = 4;
    localparam int C_ALU    = 5;
    localparam int C_REG_WR = 6;
    localparam int C_DST    = 7;
    localparam int C_DSRC   = 8;
    localparam int C_MEM_WR = 9;
    localparam int C_LOAD   = 10;
    localparam int C_STORE  = 11;
    localparam int C_EPC    = 12;
    localparam int C_CAUSE  = 13;
    localparam int C_PC_WR  = 14;
    localparam int C_SHIFT  = 15;

    logic       clk;
    logic       reset;
    opcode_t    opcode;
    funct_t     funct;
    logic       overflow;
    logic       zero;
    iord_t      iord;
    logic       mem_wr;
    logic       ir_wr;
    logic       reg_wr;
    logic       wr_a;
    logic       wr_b;
    reg_dst_t   reg_dst;
    data_src_t  data_src;
    alu_src_a_t alu_src_a;
    alu_src_b_t alu_src_b;
    alu_op_t    alu_op;
    logic       alu_out_wr;
    pc_src_t    pc_source;
    logic       pc_wr;
    logic       epc_wr;
    cause_t     cause_control;
    size_ctl_t  load_control;
    size_ctl_t  store_control;
    shift_ctl_t shift_control;
    logic [36:0] ctrl_bus;  // Every control output side by side

    logic [7:0] stim [0:FIELDS*MAX_LINES-1];
    int n_lines;
    int cycle_count = 0;
    int cycle_limit = 0;
    int checks = 0;
    int errors = 0;

    // What one instruction did between its fetch and the next
    int         cycles;
    alu_op_t    exec_alu;
    logic       seen_reg_wr;
    reg_dst_t   got_dst;
    data_src_t  got_dsrc;
    logic       seen_mem_wr;
    size_ctl_t  got_load;
    size_ctl_t  got_store;
    logic       seen_epc;
    cause_t     got_cause;
    logic       seen_pc_wr;
    shift_ctl_t got_shift;

    assign ctrl_bus = {iord, mem_wr, ir_wr, reg_wr, wr_a, wr_b, reg_dst, data_src,
                       alu_src_a, alu_src_b, alu_op, alu_out_wr, pc_source, pc_wr,
                       epc_wr, cause_control, load_control, store_control, shift_control};

    tb_clock_gen i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    control_unit i_dut (
        .clk           (clk),
        .reset         (reset),
        .opcode        (opcode),
        .funct         (funct),
        .overflow      (overflow),
        .zero          (zero),
        .iord          (iord),
        .mem_wr        (mem_wr),
        .ir_wr         (ir_wr),
        .reg_wr        (reg_wr),
        .wr_a          (wr_a),
        .wr_b          (wr_b),
        .reg_dst       (reg_dst),
        .data_src      (data_src),
        .alu_src_a     (alu_src_a),
        .alu_src_b     (alu_src_b),
        .alu_op        (alu_op),
        .alu_out_wr    (alu_out_wr),
        .pc_source     (pc_source),
        .pc_wr         (pc_wr),
        .epc_wr        (epc_wr),
        .cause_control (cause_control),
        .load_control  (load_control),
        .store_control (store_control),
        .shift_control (shift_control)
    );

    function automatic logic [7:0] field(input int line, input int col);
        logic [8:0] addr;
        addr = 9'(line * FIELDS + col);
        return stim[addr];
    endfunction

    task automatic check(input string what, input logic [63:0] actual,
                         input logic [63:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic apply_line(input int line);
        logic [31:0] rnd;
        opcode_t     op;
        op       = 6'(field(line, C_OPCODE));
        opcode   = op;
        funct    = 6'(field(line, C_FUNCT));
        overflow = (field(line, C_OVF) != 8'd0);
        if (op == `CU_OP_BEQ || op == `CU_OP_BNE) begin
            zero = (field(line, C_ZERO) != 8'd0);
        end else begin
            rnd  = $urandom();
            zero = rnd[0];  // Must not matter outside branches
        end
    endtask

    task automatic record_cycle(input int idx);
        if (idx == 3) exec_alu = alu_op;  // First cycle after decode
        if (reg_wr) begin
            seen_reg_wr = 1'b1;
            got_dst     = reg_dst;
            got_dsrc    = data_src;
        end
        if (mem_wr) seen_mem_wr = 1'b1;
        if (epc_wr) begin
            seen_epc  = 1'b1;
            got_cause = cause_control;
        end
        if (idx >= 3 && pc_wr) seen_pc_wr = 1'b1;
        got_load  = got_load | load_control;
        got_store = got_store | store_control;
        got_shift = got_shift | shift_control;
    endtask

    // Runs from fetch until the next ir_wr pulse
    task automatic measure_instruction();
        int   idx;
        logic done;
        idx         = 1;
        done        = 1'b0;
        exec_alu    = '0;
        seen_reg_wr = 1'b0;
        got_dst     = '0;
        got_dsrc    = '0;
        seen_mem_wr = 1'b0;
        got_load    = '0;
        got_store   = '0;
        seen_epc    = 1'b0;
        got_cause   = '0;
        seen_pc_wr  = 1'b0;
        got_shift   = '0;
        while (!done) begin
            @(negedge clk);
            record_cycle(idx);
            @(posedge clk);
            #1;
            if (ir_wr) begin
                done = 1'b1;
            end else begin
                idx++;
            end
        end
        cycles = idx;
    endtask

    task automatic check_line(input int line);
        string tag;
        tag = $sformatf("line %0d", line + 1);
        check({tag, " cycles"}, 64'(cycles), 64'(field(line, C_CYCLES)));
        check({tag, " exec alu_op"}, 64'(exec_alu), 64'(field(line, C_ALU)));
        check({tag, " reg_wr"}, 64'(seen_reg_wr), 64'(field(line, C_REG_WR)));
        check({tag, " reg_dst"}, 64'(got_dst), 64'(field(line, C_DST)));
        check({tag, " data_src"}, 64'(got_dsrc), 64'(field(line, C_DSRC)));
        check({tag, " mem_wr"}, 64'(seen_mem_wr), 64'(field(line, C_MEM_WR)));
        check({tag, " load_control"}, 64'(got_load), 64'(field(line, C_LOAD)));
        check({tag, " store_control"}, 64'(got_store), 64'(field(line, C_STORE)));
        check({tag, " epc_wr"}, 64'(seen_epc), 64'(field(line, C_EPC)));
        check({tag, " cause"}, 64'(got_cause), 64'(field(line, C_CAUSE)));
        check({tag, " pc_wr"}, 64'(seen_pc_wr), 64'(field(line, C_PC_WR)));
        check({tag, " shift_control"}, 64'(got_shift), 64'(field(line, C_SHIFT)));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    initial begin
        int waited;
        void'($urandom(32'h6a1820dd));
        opcode   = '0;
        funct    = '0;
        overflow = 1'b0;
        zero     = 1'b0;

        $readmemh("verification/control_unit_stimulus.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && field(n_lines, C_OPCODE) != END_MARK) begin
            n_lines++;
        end
        if (n_lines == 0) begin
            errors++;
            $display("The stimulus file holds no instruction lines");
        end
        cycle_limit = n_lines * 6 + 40;

        do begin
            @(negedge clk);
            if (reset) check("outputs during reset", 64'(ctrl_bus), 64'd0);
        end while (reset);

        // reset_start lasts one cycle, then fetch
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ir_wr);
        check("cycles from reset release to first fetch", 64'(waited), 64'd1);

        for (int i = 0; i < n_lines; i++) begin
            apply_line(i);
            measure_instruction();
            check_line(i);
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
